// File: usrp_pkg.sv
/* Shared widths, sample and register types, Wishbone request and response
   structs and the identity word for the clk64 sample router */
package usrp_pkg;

   localparam int SAMPLE_W  = 16;
   localparam int DAC_W     = 14;
   localparam int WB_ADDR_W = 7;
   localparam int WB_DATA_W = 32;

   typedef logic [SAMPLE_W-1:0]  sample_t;
   typedef logic [DAC_W-1:0]     dac_word_t;
   typedef logic [WB_ADDR_W-1:0] wb_addr_t;
   typedef logic [WB_DATA_W-1:0] wb_data_t;

   // Bit 3 enable, bit 1 chain, bit 0 Q over I
   typedef logic [3:0] dac_sel_t;

   // dac0 selector sits in the low nibble
   typedef struct packed {
      dac_sel_t dac3_sel;
      dac_sel_t dac2_sel;
      dac_sel_t dac1_sel;
      dac_sel_t dac0_sel;
   } tx_mux_cfg_t;

   typedef struct packed {
      logic counter_en;
      logic loopback_en;
   } mode_t;

   // Outputs of the two transmit chains
   typedef struct packed {
      sample_t i0;
      sample_t q0;
      sample_t i1;
      sample_t q1;
   } tx_bb_t;

   // ADC baseband samples
   typedef struct packed {
      sample_t i0;
      sample_t q0;
      sample_t i1;
      sample_t q1;
   } rx_bb_t;

   typedef struct packed {
      sample_t ch0;
      sample_t ch1;
      sample_t ch2;
      sample_t ch3;
   } rx_ch_t;

   // Wishbone classic master to slave
   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      wb_addr_t adr;
      wb_data_t dat;
   } wb_req_t;

   typedef struct packed {
      wb_data_t dat;
      logic     ack;
   } wb_rsp_t;

   localparam wb_data_t ID_WORD = 32'hF0F0_931A;

endpackage

// File: settings_regs.sv
/* Wishbone classic slave with the DAC mux and mode registers
   and the read-only identity word */
`timescale 1ns/1ps

module settings_regs
   import usrp_pkg::*;
#(
   parameter wb_addr_t P_TX_MUX_ADDR = 7'd38,
   parameter wb_addr_t P_MODE_ADDR   = 7'd39,
   parameter wb_addr_t P_ID_ADDR     = 7'd3
)
(
   input  logic        clk64,
   input  logic        rx_dsp_reset,
   input  wb_req_t     i_wb,
   output wb_rsp_t     o_wb,
   output tx_mux_cfg_t o_tx_mux,
   output mode_t       o_mode
);

   logic        ack_q;
   wb_data_t    dat_q;
   logic        req_valid;
   logic        wr_en;
   wb_data_t    rd_data;
   tx_mux_cfg_t tx_mux_q;
   mode_t       mode_q;

   // New request only while ack is low, so each cycle gets one ack
   assign req_valid = i_wb.cyc && i_wb.stb && !ack_q;
   assign wr_en     = req_valid && i_wb.we;

   // Readback select
   always_comb
   begin
      case (i_wb.adr)
         P_TX_MUX_ADDR:
            rd_data = wb_data_t'(tx_mux_q);
         P_MODE_ADDR:
            rd_data = wb_data_t'(mode_q);
         P_ID_ADDR:
            rd_data = ID_WORD;
         default:
            rd_data = '0;
      endcase
   end

   // Bus handshake and read data
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         ack_q <= 1'b0;
         dat_q <= '0;
      end
      else
      begin
         ack_q <= req_valid;
         if (req_valid)
            dat_q <= rd_data;
      end
   end

   // Register writes land on the ack edge
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         tx_mux_q <= '0;
         mode_q   <= '0;
      end
      else if (wr_en)
      begin
         case (i_wb.adr)
            P_TX_MUX_ADDR:
               tx_mux_q <= tx_mux_cfg_t'(i_wb.dat[$bits(tx_mux_cfg_t)-1:0]);
            P_MODE_ADDR:
               mode_q <= mode_t'(i_wb.dat[$bits(mode_t)-1:0]);
            default:
               ;  // identity and unmapped addresses ignore writes
         endcase
      end
   end

   assign o_wb.dat = dat_q;
   assign o_wb.ack = ack_q;

   assign o_tx_mux = tx_mux_q;
   assign o_mode   = mode_q;

endmodule

// File: dac_router.sv
/* TX lane selection from the two chains and registered
   interleave onto the two DAC ports with txsync */
`timescale 1ns/1ps

module dac_router
   import usrp_pkg::*;
(
   input  logic        clk64,
   input  logic        rx_dsp_reset,
   input  tx_mux_cfg_t i_tx_mux,
   input  tx_bb_t      i_tx_bb,
   input  logic        i_tx_sample_strobe,
   output dac_word_t   o_tx_a,
   output dac_word_t   o_tx_b,
   output logic        o_txsync
);

   dac_word_t lane_a_a;
   dac_word_t lane_b_a;
   dac_word_t lane_a_b;
   dac_word_t lane_b_b;
   dac_word_t tx_a_q;
   dac_word_t tx_b_q;
   logic      txsync_q;

   // Selector picks chain and I/Q or zero and keeps the top 14 bits
   function automatic dac_word_t pick_lane(input dac_sel_t sel, input tx_bb_t bb);
      sample_t s;
      if (!sel[3])
         s = '0;
      else if (sel[1])
         s = sel[0] ? bb.q1 : bb.i1;
      else
         s = sel[0] ? bb.q0 : bb.i0;
      return s[SAMPLE_W-1 -: DAC_W];
   endfunction

   // dac0/dac1 share port A, dac2/dac3 share port B
   assign lane_a_a = pick_lane(i_tx_mux.dac0_sel, i_tx_bb);
   assign lane_b_a = pick_lane(i_tx_mux.dac1_sel, i_tx_bb);
   assign lane_a_b = pick_lane(i_tx_mux.dac2_sel, i_tx_bb);
   assign lane_b_b = pick_lane(i_tx_mux.dac3_sel, i_tx_bb);

   // Codes and marker leave on the same edge
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         tx_a_q   <= '0;
         tx_b_q   <= '0;
         txsync_q <= 1'b0;
      end
      else
      begin
         txsync_q <= i_tx_sample_strobe;
         tx_a_q   <= i_tx_sample_strobe ? lane_b_a : lane_a_a;
         tx_b_q   <= i_tx_sample_strobe ? lane_b_b : lane_a_b;
      end
   end

   assign o_tx_a   = tx_a_q;
   assign o_tx_b   = tx_b_q;
   assign o_txsync = txsync_q;

endmodule

// File: rx_source_select.sv
/* Receive channel source select with the debug counter,
   the TX loopback latch and registered channel outputs */
`timescale 1ns/1ps

module rx_source_select
   import usrp_pkg::*;
(
   input  logic   clk64,
   input  logic   rx_dsp_reset,
   input  mode_t  i_mode,
   input  logic   i_enable_rx,
   input  logic   i_hb_strobe,
   input  logic   i_strobe_interp,
   input  tx_bb_t i_tx_bb,
   input  rx_bb_t i_rx_bb,
   output rx_ch_t o_rx
);

   sample_t debug_cnt;
   sample_t loopback_i;
   sample_t loopback_q;
   rx_ch_t  rx_next;
   rx_ch_t  rx_q;

   // Debug counter held at zero while the receive side is off
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         debug_cnt <= '0;
      else if (!i_enable_rx)
         debug_cnt <= '0;
      else if (i_hb_strobe)
         debug_cnt <= debug_cnt + sample_t'(2);
   end

   // Last TX sample of chain 0 taken on the interpolator strobe
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         loopback_i <= '0;
         loopback_q <= '0;
      end
      else if (i_strobe_interp)
      begin
         loopback_i <= i_tx_bb.i0;
         loopback_q <= i_tx_bb.q0;
      end
   end

   // Counter first, then loopback, then ADC
   always_comb
   begin
      if (i_mode.counter_en)
      begin
         rx_next.ch0 = debug_cnt;
         rx_next.ch1 = debug_cnt + sample_t'(1);
      end
      else if (i_mode.loopback_en)
      begin
         rx_next.ch0 = loopback_i;
         rx_next.ch1 = loopback_q;
      end
      else
      begin
         rx_next.ch0 = i_rx_bb.i0;
         rx_next.ch1 = i_rx_bb.q0;
      end
      rx_next.ch2 = i_rx_bb.i1;
      rx_next.ch3 = i_rx_bb.q1;
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         rx_q <= '0;
      else
         rx_q <= rx_next;
   end

   assign o_rx = rx_q;

endmodule

// File: usrp_sample_router.sv
/* Top level of the clk64 sample router: settings registers,
   DAC routing and receive source select */
`timescale 1ns/1ps

module usrp_sample_router
   import usrp_pkg::*;
#(
   parameter wb_addr_t P_TX_MUX_ADDR = 7'd38,
   parameter wb_addr_t P_MODE_ADDR   = 7'd39,
   parameter wb_addr_t P_ID_ADDR     = 7'd3
)
(
   input  logic      clk64,
   input  logic      rx_dsp_reset,
   input  wb_req_t   i_wb,
   output wb_rsp_t   o_wb,
   input  tx_bb_t    i_tx_bb,
   input  logic      i_tx_sample_strobe,
   input  logic      i_strobe_interp,
   input  rx_bb_t    i_rx_bb,
   input  logic      i_hb_strobe,
   input  logic      i_enable_rx,
   output dac_word_t o_tx_a,
   output dac_word_t o_tx_b,
   output logic      o_txsync,
   output rx_ch_t    o_rx
);

   tx_mux_cfg_t tx_mux;
   mode_t       mode;

   settings_regs #(
      .P_TX_MUX_ADDR (P_TX_MUX_ADDR),
      .P_MODE_ADDR   (P_MODE_ADDR),
      .P_ID_ADDR     (P_ID_ADDR)
   ) u_settings_regs (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_wb         (i_wb),
      .o_wb         (o_wb),
      .o_tx_mux     (tx_mux),
      .o_mode       (mode)
   );

   // Transmit side
   dac_router u_dac_router (
      .clk64              (clk64),
      .rx_dsp_reset       (rx_dsp_reset),
      .i_tx_mux           (tx_mux),
      .i_tx_bb            (i_tx_bb),
      .i_tx_sample_strobe (i_tx_sample_strobe),
      .o_tx_a             (o_tx_a),
      .o_tx_b             (o_tx_b),
      .o_txsync           (o_txsync)
   );

   // Receive side
   rx_source_select u_rx_source_select (
      .clk64           (clk64),
      .rx_dsp_reset    (rx_dsp_reset),
      .i_mode          (mode),
      .i_enable_rx     (i_enable_rx),
      .i_hb_strobe     (i_hb_strobe),
      .i_strobe_interp (i_strobe_interp),
      .i_tx_bb         (i_tx_bb),
      .i_rx_bb         (i_rx_bb),
      .o_rx            (o_rx)
   );

endmodule

// File: tb_clkgen.sv
/* Testbench clock and reset pulse */
`timescale 1ns/1ps

module tb_clkgen
#(
   parameter real P_PERIOD_NS  = 40.0,
   parameter int  P_RST_CYCLES = 4
)
(
   output logic clk64,
   output logic rx_dsp_reset
);

   initial
   begin
      clk64 = 1'b0;
      forever #(P_PERIOD_NS / 2.0) clk64 = ~clk64;
   end

   // Released 1 ns after the last reset edge
   initial
   begin
      rx_dsp_reset = 1'b1;
      repeat (P_RST_CYCLES) @(posedge clk64);
      #1 rx_dsp_reset = 1'b0;
   end

endmodule

// File: usrp_sample_router_sva.sv
/* Bus handshake and txsync assertions, bound into the sample router */
`timescale 1ns/1ps

module usrp_sample_router_sva
   import usrp_pkg::*;
(
   input logic    clk64,
   input logic    rx_dsp_reset,
   input wb_req_t i_wb_req,
   input wb_rsp_t i_wb_rsp,
   input logic    i_tx_sample_strobe,
   input logic    i_txsync
);

   int unsigned assert_fails = 0;

   // ack follows a request seen on the previous edge
   a_ack_after_req: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      i_wb_rsp.ack |-> $past(i_wb_req.cyc && i_wb_req.stb))
   else
   begin
      assert_fails++;
      $error("ack raised without a request on the previous edge");
   end

   a_ack_single: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      i_wb_rsp.ack |=> !i_wb_rsp.ack)
   else
   begin
      assert_fails++;
      $error("ack held high for two cycles");
   end

   // Marker is the strobe one edge late
   a_txsync_delay: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      !$past(rx_dsp_reset) |-> i_txsync == $past(i_tx_sample_strobe))
   else
   begin
      assert_fails++;
      $error("txsync does not match the previous sample strobe");
   end

endmodule

bind usrp_sample_router usrp_sample_router_sva u_sva (
   .clk64              (clk64),
   .rx_dsp_reset       (rx_dsp_reset),
   .i_wb_req           (i_wb),
   .i_wb_rsp           (o_wb),
   .i_tx_sample_strobe (i_tx_sample_strobe),
   .i_txsync           (o_txsync)
);

// File: tb_usrp_sample_router.sv
/* Table-driven testbench for the sample router with Wishbone tasks,
   reference lane and channel values, checks and the result line */
`timescale 1ns/1ps

module tb_usrp_sample_router
   import usrp_pkg::*;
;

   localparam wb_addr_t TX_MUX_ADDR   = 7'd38;
   localparam wb_addr_t MODE_ADDR     = 7'd39;
   localparam wb_addr_t ID_ADDR       = 7'd3;
   localparam wb_addr_t UNMAPPED_ADDR = 7'd5;
   localparam int ACK_TIMEOUT = 20;
   localparam int RST_TIMEOUT = 50;
   localparam int SETTLE      = 3;
   localparam int HB_PULSES   = 5;

   typedef struct {
      string       name;
      tx_mux_cfg_t tx_mux;
      mode_t       mode;
      logic        txsync;
      logic        enable_rx;
   } row_t;

   logic        clk64;
   logic        rx_dsp_reset;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   tx_bb_t      tx_bb;
   rx_bb_t      rx_bb;
   logic        tx_sample_strobe;
   logic        strobe_interp;
   logic        hb_strobe;
   logic        enable_rx;
   dac_word_t   tx_a;
   dac_word_t   tx_b;
   logic        txsync;
   rx_ch_t      rx;

   row_t        rows[$];
   logic [31:0] seed;
   sample_t     lb_i;
   sample_t     lb_q;
   sample_t     exp_cnt;
   int          check_cnt;
   int          err_cnt;
   int          fail_cnt;

   tb_clkgen u_clkgen (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset)
   );

   usrp_sample_router u_dut (
      .clk64              (clk64),
      .rx_dsp_reset       (rx_dsp_reset),
      .i_wb               (wb_req),
      .o_wb               (wb_rsp),
      .i_tx_bb            (tx_bb),
      .i_tx_sample_strobe (tx_sample_strobe),
      .i_strobe_interp    (strobe_interp),
      .i_rx_bb            (rx_bb),
      .i_hb_strobe        (hb_strobe),
      .i_enable_rx        (enable_rx),
      .o_tx_a             (tx_a),
      .o_tx_b             (tx_b),
      .o_txsync           (txsync),
      .o_rx               (rx)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Upper half of each LCG state gives one sample
   task automatic random_samples();
      logic [127:0] v;
      int           k;
      for (k = 0; k < 8; k++)
      begin
         seed = lcg_next(seed);
         v[k*16 +: 16] = seed[31:16];
      end
      tx_bb = v[127:64];
      rx_bb = v[63:0];
   endtask

   // Inputs change and outputs are read 2 ns after the edge
   task automatic step();
      @(posedge clk64);
      #2;
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      check_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         $display("ERR %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // Expected DAC code from a pool indexed by {chain, Q}
   function automatic dac_word_t expect_lane(input dac_sel_t sel, input tx_bb_t bb);
      sample_t pool [4];
      sample_t s;
      pool[0] = bb.i0;
      pool[1] = bb.q0;
      pool[2] = bb.i1;
      pool[3] = bb.q1;
      s = sel[3] ? pool[sel[1:0]] : 16'h0000;
      return dac_word_t'(s >> 2);
   endfunction

   task automatic wb_access(input wb_addr_t adr, input logic we, input wb_data_t wdat,
                            output wb_data_t rdat);
      int   n;
      logic got_ack;
      got_ack    = 1'b0;
      rdat       = '0;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      for (n = 0; n < ACK_TIMEOUT && !got_ack; n++)
      begin
         step();
         got_ack = wb_rsp.ack;
      end
      if (got_ack)
         rdat = wb_rsp.dat;
      else
      begin
         fail_cnt++;
         $display("Bus access to address %0d got no ack in %0d cycles", adr, ACK_TIMEOUT);
      end
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
   endtask

   task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
      wb_data_t unused_rd;
      wb_access(adr, 1'b1, dat, unused_rd);
   endtask

   task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
      wb_access(adr, 1'b0, '0, dat);
   endtask

   task automatic add_row(input string name, input tx_mux_cfg_t mux, input mode_t mode,
                          input logic sync, input logic en);
      row_t r;
      r.name      = name;
      r.tx_mux    = mux;
      r.mode      = mode;
      r.txsync    = sync;
      r.enable_rx = en;
      rows.push_back(r);
   endtask

   task automatic apply_row(input row_t r);
      sample_t  e0;
      sample_t  e1;
      dac_sel_t sel_a;
      dac_sel_t sel_b;
      wb_write(TX_MUX_ADDR, wb_data_t'(r.tx_mux));
      wb_write(MODE_ADDR, wb_data_t'(r.mode));
      random_samples();
      tx_sample_strobe = r.txsync;
      enable_rx        = r.enable_rx;
      if (!r.enable_rx)
         exp_cnt = '0;
      repeat (SETTLE) step();
      // txsync high sends the odd lane of each port
      sel_a = r.txsync ? r.tx_mux.dac1_sel : r.tx_mux.dac0_sel;
      sel_b = r.txsync ? r.tx_mux.dac3_sel : r.tx_mux.dac2_sel;
      check_val({r.name, " tx_a"}, 32'(expect_lane(sel_a, tx_bb)), 32'(tx_a));
      check_val({r.name, " tx_b"}, 32'(expect_lane(sel_b, tx_bb)), 32'(tx_b));
      check_val({r.name, " txsync"}, 32'(r.txsync), 32'(txsync));
      if (r.mode.counter_en)
      begin
         e0 = exp_cnt;
         e1 = exp_cnt + 16'd1;
      end
      else if (r.mode.loopback_en)
      begin
         e0 = lb_i;
         e1 = lb_q;
      end
      else
      begin
         e0 = rx_bb.i0;
         e1 = rx_bb.q0;
      end
      check_val({r.name, " ch0"}, 32'(e0), 32'(rx.ch0));
      check_val({r.name, " ch1"}, 32'(e1), 32'(rx.ch1));
      check_val({r.name, " ch2"}, 32'(rx_bb.i1), 32'(rx.ch2));
      check_val({r.name, " ch3"}, 32'(rx_bb.q1), 32'(rx.ch3));
   endtask

   initial
   begin
      int       n;
      wb_data_t rd;
      seed             = 32'h7cf0;
      check_cnt        = 0;
      err_cnt          = 0;
      fail_cnt         = 0;
      wb_req           = '0;
      // Non-zero inputs while reset is held
      random_samples();
      tx_sample_strobe = 1'b1;
      strobe_interp    = 1'b0;
      hb_strobe        = 1'b1;
      enable_rx        = 1'b1;
      exp_cnt          = '0;
      lb_i             = '0;
      lb_q             = '0;

      for (n = 0; n < RST_TIMEOUT && rx_dsp_reset !== 1'b0; n++)
         step();
      if (rx_dsp_reset !== 1'b0)
      begin
         fail_cnt++;
         $display("Reset was not released within %0d cycles", RST_TIMEOUT);
      end
      check_val("reset tx_a", 32'h0, 32'(tx_a));
      check_val("reset tx_b", 32'h0, 32'(tx_b));
      check_val("reset txsync", 32'h0, 32'(txsync));
      check_val("reset rx low", 32'h0, rx[31:0]);
      check_val("reset rx high", 32'h0, rx[63:32]);
      check_val("reset ack", 32'h0, 32'(wb_rsp.ack));
      tx_sample_strobe = 1'b0;
      hb_strobe        = 1'b0;

      // Register file readback
      wb_write(TX_MUX_ADDR, 32'hFFFF_5A3C);
      wb_read(TX_MUX_ADDR, rd);
      check_val("tx_mux readback", 32'h0000_5A3C, rd);
      wb_write(MODE_ADDR, 32'hFFFF_FFFE);
      wb_read(MODE_ADDR, rd);
      check_val("mode readback", 32'h0000_0002, rd);
      wb_write(ID_ADDR, 32'h0);
      wb_read(ID_ADDR, rd);
      check_val("identity word", 32'hF0F0_931A, rd);
      wb_write(UNMAPPED_ADDR, 32'hDEAD_BEEF);
      wb_read(UNMAPPED_ADDR, rd);
      check_val("unmapped read", 32'h0, rd);
      wb_read(TX_MUX_ADDR, rd);
      check_val("tx_mux after unmapped write", 32'h0000_5A3C, rd);

      // Loopback latch, then new TX samples that must not show up
      wb_write(MODE_ADDR, 32'h1);
      random_samples();
      lb_i          = tx_bb.i0;
      lb_q          = tx_bb.q0;
      strobe_interp = 1'b1;
      step();
      strobe_interp = 1'b0;
      random_samples();
      repeat (SETTLE) step();
      check_val("loopback ch0", 32'(lb_i), 32'(rx.ch0));
      check_val("loopback ch1", 32'(lb_q), 32'(rx.ch1));

      add_row("lanes_8_9", 16'hF9E8, 2'b00, 1'b0, 1'b1);
      add_row("lanes_a_b", 16'hB0A1, 2'b00, 1'b1, 1'b1);
      add_row("lanes_c_d", 16'h2D3C, 2'b00, 1'b0, 1'b1);
      add_row("lanes_e_f", 16'hF8E9, 2'b00, 1'b1, 1'b1);
      add_row("lanes_0_1", 16'hA1B0, 2'b00, 1'b0, 1'b1);
      add_row("lanes_2_3", 16'h3C2D, 2'b00, 1'b1, 1'b1);
      add_row("lanes_4_5", 16'h6574, 2'b00, 1'b0, 1'b1);
      add_row("lanes_6_7", 16'h7465, 2'b00, 1'b1, 1'b1);
      add_row("loopback_hold", 16'h9C8E, 2'b01, 1'b0, 1'b1);
      add_row("counter_idle", 16'hC9E8, 2'b10, 1'b1, 1'b0);
      foreach (rows[i])
         apply_row(rows[i]);

      // Debug counter with loopback also set
      wb_write(MODE_ADDR, 32'h3);
      enable_rx = 1'b0;
      step();
      enable_rx = 1'b1;
      exp_cnt   = '0;
      hb_strobe = 1'b1;
      for (n = 0; n < HB_PULSES; n++)
      begin
         step();
         exp_cnt = exp_cnt + 16'd2;
      end
      hb_strobe = 1'b0;
      repeat (SETTLE) step();
      check_val("counter ch0", 32'(exp_cnt), 32'(rx.ch0));
      check_val("counter ch1", 32'(exp_cnt + 16'd1), 32'(rx.ch1));
      enable_rx = 1'b0;
      exp_cnt   = '0;
      repeat (SETTLE) step();
      check_val("counter cleared ch0", 32'h0, 32'(rx.ch0));
      check_val("counter cleared ch1", 32'h1, 32'(rx.ch1));

      $display("Checks: %0d, value errors: %0d, other failures: %0d, assertion failures: %0d",
               check_cnt, err_cnt, fail_cnt, u_dut.u_sva.assert_fails);
      if (err_cnt == 0 && fail_cnt == 0 && u_dut.u_sva.assert_fails == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: compile.f
usrp_pkg.sv
settings_regs.sv
dac_router.sv
rx_source_select.sv
usrp_sample_router.sv
tb_clkgen.sv
usrp_sample_router_sva.sv
tb_usrp_sample_router.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the sample router testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=tb_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f compile.f --top-module tb_usrp_sample_router \
   -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

# Keep running past assertion errors so the testbench prints its result
"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
   echo "Simulation run passed"
   exit 0
else
   echo "Simulation run failed"
   exit 1
fi
